//--- vlog.f
+incdir+verif
src/memoryPkg.sv
src/elementAlu.sv
src/elementStore.sv
src/sizeTable.sv
src/arrayAllocator.sv
src/commandControl.sv
src/arrayMemory.sv
verif/tbArrayMemory.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the array memory testbench with Verilator, runs it into sim.log
# and exits non-zero when the log reports a failure.

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tbArrayMemory -f vlog.f -o simArrayMemory \
  && ./obj_dir/simArrayMemory > sim.log 2>&1 \
  || { echo "Build or simulation run did not complete"; exit 1; }

cat sim.log

grep -q "Simulation FAILED" sim.log && { echo "Testbench reported failure"; exit 1; }
grep -q "Simulation PASSED" sim.log || { echo "No pass message in sim.log"; exit 1; }
echo "Run finished without failures"
exit 0

//--- verif/tbVectors.svh
/*
  Vector table for the array memory testbench, included inside the testbench
  module. Columns: name, action, array, index, in, expected out, check out flag,
  expected error. Each row is one action on one clock.
*/
task automatic loadVectors();
  // Allocation and reuse of freed numbers
  addVector("allocA", memoryPkg::actAlloc, 0, 0, 'h0000, 'h0000, 1, memoryPkg::errNone);
  addVector("allocB", memoryPkg::actAlloc, 0, 0, 'h0000, 'h0001, 1, memoryPkg::errNone);
  addVector("allocC", memoryPkg::actAlloc, 0, 0, 'h0000, 'h0002, 1, memoryPkg::errNone);
  addVector("freeB", memoryPkg::actFree, 1, 0, 'h0000, 'h0000, 0, memoryPkg::errNone);
  addVector("freeC", memoryPkg::actFree, 2, 0, 'h0000, 'h0000, 0, memoryPkg::errNone);
  addVector("reuseC", memoryPkg::actAlloc, 0, 0, 'h0000, 'h0002, 1, memoryPkg::errNone);
  addVector("reuseB", memoryPkg::actAlloc, 0, 0, 'h0000, 'h0001, 1, memoryPkg::errNone);
  // Access errors leave out and state alone
  addVector("badCode", memoryPkg::actionT'(7), 0, 0, 'h0000, 'h0001, 1,
            memoryPkg::errBadAction);
  addVector("idleHold", memoryPkg::actIdle, 0, 0, 'h0000, 'h0001, 1, memoryPkg::errBadAction);
  addVector("readNa", memoryPkg::actRead, 5, 0, 'h0000, 'h0001, 1, memoryPkg::errNotAllocated);
  addVector("writeNa", memoryPkg::actWrite, 5, 0, 'h5555, 'h0001, 1, memoryPkg::errNotAllocated);
  addVector("refreeC", memoryPkg::actFree, 2, 0, 'h0000, 'h0001, 1, memoryPkg::errNone);
  addVector("readFr", memoryPkg::actRead, 2, 0, 'h0000, 'h0001, 1, memoryPkg::errFreed);
  addVector("freeTwice", memoryPkg::actFree, 2, 0, 'h0000, 'h0001, 1, memoryPkg::errFreed);
  addVector("pushFr", memoryPkg::actPush, 2, 0, 'h7777, 'h0001, 1, memoryPkg::errFreed);
  addVector("reuseC2", memoryPkg::actAlloc, 0, 0, 'h0000, 'h0002, 1, memoryPkg::errNone);
  addVector("allocD", memoryPkg::actAlloc, 0, 0, 'h0000, 'h0003, 1, memoryPkg::errNone);
  addVector("allocE", memoryPkg::actAlloc, 0, 0, 'h0000, 'h0004, 1, memoryPkg::errNone);
  addVector("allocF", memoryPkg::actAlloc, 0, 0, 'h0000, 'h0005, 1, memoryPkg::errNone);
  addVector("allocG", memoryPkg::actAlloc, 0, 0, 'h0000, 'h0006, 1, memoryPkg::errNone);
  addVector("allocH", memoryPkg::actAlloc, 0, 0, 'h0000, 'h0007, 1, memoryPkg::errNone);
  addVector("allocOom", memoryPkg::actAlloc, 0, 0, 'h0000, 'h0007, 1, memoryPkg::errOutOfMemory);
  // Write past the end grows the array
  addVector("write5", memoryPkg::actWrite, 0, 5, 'h1234, 'h1234, 1, memoryPkg::errNone);
  addVector("size6", memoryPkg::actSize, 0, 0, 'h0000, 'h0006, 1, memoryPkg::errNone);
  addVector("read5", memoryPkg::actRead, 0, 5, 'h0000, 'h1234, 1, memoryPkg::errNone);
  addVector("read6", memoryPkg::actRead, 0, 6, 'h0000, 'h1234, 1, memoryPkg::errOutOfBounds);
  // Fill array 3, then drain it in reverse
  addVector("push0", memoryPkg::actPush, 3, 0, 'h00a0, 'h0000, 0, memoryPkg::errNone);
  addVector("push1", memoryPkg::actPush, 3, 0, 'h00a1, 'h0000, 0, memoryPkg::errNone);
  addVector("push2", memoryPkg::actPush, 3, 0, 'h00a2, 'h0000, 0, memoryPkg::errNone);
  addVector("push3", memoryPkg::actPush, 3, 0, 'h00a3, 'h0000, 0, memoryPkg::errNone);
  addVector("push4", memoryPkg::actPush, 3, 0, 'h00a4, 'h0000, 0, memoryPkg::errNone);
  addVector("push5", memoryPkg::actPush, 3, 0, 'h00a5, 'h0000, 0, memoryPkg::errNone);
  addVector("push6", memoryPkg::actPush, 3, 0, 'h00a6, 'h0000, 0, memoryPkg::errNone);
  addVector("push7", memoryPkg::actPush, 3, 0, 'h00a7, 'h0000, 0, memoryPkg::errNone);
  addVector("push8", memoryPkg::actPush, 3, 0, 'h00ee, 'h1234, 1, memoryPkg::errFull);
  addVector("pop7", memoryPkg::actPop, 3, 0, 'h0000, 'h00a7, 1, memoryPkg::errNone);
  addVector("pop6", memoryPkg::actPop, 3, 0, 'h0000, 'h00a6, 1, memoryPkg::errNone);
  addVector("pop5", memoryPkg::actPop, 3, 0, 'h0000, 'h00a5, 1, memoryPkg::errNone);
  addVector("pop4", memoryPkg::actPop, 3, 0, 'h0000, 'h00a4, 1, memoryPkg::errNone);
  addVector("pop3", memoryPkg::actPop, 3, 0, 'h0000, 'h00a3, 1, memoryPkg::errNone);
  addVector("pop2", memoryPkg::actPop, 3, 0, 'h0000, 'h00a2, 1, memoryPkg::errNone);
  addVector("pop1", memoryPkg::actPop, 3, 0, 'h0000, 'h00a1, 1, memoryPkg::errNone);
  addVector("pop0", memoryPkg::actPop, 3, 0, 'h0000, 'h00a0, 1, memoryPkg::errNone);
  addVector("popNone", memoryPkg::actPop, 3, 0, 'h0000, 'h00a0, 1, memoryPkg::errEmpty);
  // Rejected actions left no trace in sizes or elements
  addVector("sizeNone", memoryPkg::actSize, 3, 0, 'h0000, 'h0000, 1, memoryPkg::errNone);
  addVector("writeF1", memoryPkg::actWrite, 5, 1, 'h0b0b, 'h0b0b, 1, memoryPkg::errNone);
  addVector("readF0", memoryPkg::actRead, 5, 0, 'h0000, 'h0000, 1, memoryPkg::errNone);
  addVector("writeC1", memoryPkg::actWrite, 2, 1, 'h0c0c, 'h0c0c, 1, memoryPkg::errNone);
  addVector("readC0", memoryPkg::actRead, 2, 0, 'h0000, 'h0000, 1, memoryPkg::errNone);
  // Modify actions on element 0 of array 4
  addVector("seed", memoryPkg::actWrite, 4, 0, 'hff00, 'hff00, 1, memoryPkg::errNone);
  addVector("add", memoryPkg::actAdd, 4, 0, 'h0101, 'h0001, 1, memoryPkg::errNone);
  addVector("addAft", memoryPkg::actAddAfter, 4, 0, 'h0001, 'h0001, 1, memoryPkg::errNone);
  addVector("readSum", memoryPkg::actRead, 4, 0, 'h0000, 'h0002, 1, memoryPkg::errNone);
  addVector("sub", memoryPkg::actSubtract, 4, 0, 'h0003, 'hffff, 1, memoryPkg::errNone);
  addVector("subAft", memoryPkg::actSubAfter, 4, 0, 'hffff, 'hffff, 1, memoryPkg::errNone);
  addVector("or", memoryPkg::actOr, 4, 0, 'h0f11, 'h0f11, 1, memoryPkg::errNone);
  addVector("xor", memoryPkg::actXor, 4, 0, 'h00ff, 'h0fee, 1, memoryPkg::errNone);
  addVector("and", memoryPkg::actAnd, 4, 0, 'h00f0, 'h00e0, 1, memoryPkg::errNone);
  addVector("notLog1", memoryPkg::actNotLogical, 4, 0, 'h0000, 'h0000, 1, memoryPkg::errNone);
  addVector("notLog2", memoryPkg::actNotLogical, 4, 0, 'h0000, 'h0001, 1, memoryPkg::errNone);
  addVector("not", memoryPkg::actNot, 4, 0, 'h0000, 'hfffe, 1, memoryPkg::errNone);
  addVector("readMod", memoryPkg::actRead, 4, 0, 'h0000, 'hfffe, 1, memoryPkg::errNone);
  addVector("addOob", memoryPkg::actAdd, 4, 1, 'h0001, 'hfffe, 1, memoryPkg::errOutOfBounds);
  addVector("readKept", memoryPkg::actRead, 4, 0, 'h0000, 'hfffe, 1, memoryPkg::errNone);
endtask

//--- verif/tbArrayMemory.sv
/*
  Testbench for the array memory. Applies the vector table one action per
  clock on falling edges and checks done, error and out one cycle later.
*/
`timescale 1ns/1ps

module tbArrayMemory;

  localparam int AddressBits = 3;
  localparam int IndexBits   = 3;
  localparam int DataBits    = 16;
  localparam int ResetCycles = 16;
  localparam int ClockPeriod = 100;

  logic                   clock;
  logic                   arstN;
  memoryPkg::actionT      action;
  logic [AddressBits-1:0] array;
  logic [IndexBits-1:0]   index;
  logic [DataBits-1:0]    in;
  logic [DataBits-1:0]    out;
  memoryPkg::errorT       error;
  logic                   done;

  string               names[$];                    // Vector table columns
  memoryPkg::actionT   actions[$];
  int                  arrays[$];
  int                  indexes[$];
  logic [DataBits-1:0] inputs[$];
  logic [DataBits-1:0] expOuts[$];
  bit                  checkOuts[$];
  memoryPkg::errorT    expErrors[$];
  int                  errorCount;
  bit                  tableReady;

  arrayMemory #(.AddressBits(AddressBits), .IndexBits(IndexBits), .DataBits(DataBits)) DUT (
    .clock, .arstN, .action, .array, .index, .in, .out, .error, .done
  );

  always #(ClockPeriod / 2) clock = ~clock;

  task automatic addVector(input string name, input memoryPkg::actionT act, input int arr,
                           input int idx, input logic [DataBits-1:0] value,
                           input logic [DataBits-1:0] expOut, input bit chkOut,
                           input memoryPkg::errorT expErr);
    names.push_back(name);
    actions.push_back(act);
    arrays.push_back(arr);
    indexes.push_back(idx);
    inputs.push_back(value);
    expOuts.push_back(expOut);
    checkOuts.push_back(chkOut);
    expErrors.push_back(expErr);
  endtask

  `include "tbVectors.svh"

  task automatic checkReset();
    if (out !== '0) begin
      $display("[ERROR] reset: out expected 0x0000, got 0x%h", out);
      errorCount++;
    end
    if (error !== memoryPkg::errNone || done !== 1'b0) begin
      $display("[ERROR] reset: error/done expected errNone/0, got %s/%b", error.name(), done);
      errorCount++;
    end
  endtask

  task automatic applyVector(input int n);
    action = actions[n];
    array  = AddressBits'(arrays[n]);
    index  = IndexBits'(indexes[n]);
    in     = inputs[n];
  endtask

  task automatic checkVector(input int n);
    logic expDone;

    expDone = actions[n] != memoryPkg::actIdle;     // Pulse only after real actions
    if (done !== expDone) begin
      $display("[ERROR] %s: done expected %b, got %b", names[n], expDone, done);
      errorCount++;
    end
    if (error !== expErrors[n]) begin
      $display("[ERROR] %s: error expected %s, got %s", names[n], expErrors[n].name(),
               error.name());
      errorCount++;
    end
    if (checkOuts[n] && out !== expOuts[n]) begin
      $display("[ERROR] %s: out expected 0x%h, got 0x%h", names[n], expOuts[n], out);
      errorCount++;
    end
  endtask

  initial begin
    clock      = 1'b0;
    arstN      = 1'b0;
    action     = memoryPkg::actIdle;
    array      = '0;
    index      = '0;
    in         = '0;
    errorCount = 0;
    tableReady = 1'b0;
    loadVectors();
    tableReady = 1'b1;
    repeat (ResetCycles) @(negedge clock);
    arstN = 1'b1;
    checkReset();
    for (int n = 0; n < names.size(); n++) begin
      applyVector(n);
      @(negedge clock);                             // Result registered at the rising edge
      checkVector(n);
    end
    action = memoryPkg::actIdle;
    $display("Finished %0d vectors with %0d errors", names.size(), errorCount);
    if (errorCount == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // Reset, every vector and some slack
  initial begin
    wait (tableReady);
    #((ResetCycles + names.size() + 10) * ClockPeriod);
    $display("Watchdog expired before the vector table was finished");
    $display("Simulation FAILED");
    $finish;
  end

endmodule

//--- src/arrayMemory.sv
/*
  Array memory top level. Takes one action per clock on level inputs and
  returns out, error and a done pulse one cycle later.
*/
`timescale 1ns/1ps

module arrayMemory #(
  parameter int AddressBits = 3,                    // Bits in an array number
  parameter int IndexBits   = 3,                    // Bits in an element index
  parameter int DataBits    = 16                    // Width of an element
) (
  input  logic                   clock,
  input  logic                   arstN,
  input  memoryPkg::actionT      action,            // Action for this cycle
  input  logic [AddressBits-1:0] array,             // Array to work on
  input  logic [IndexBits-1:0]   index,             // Element within array
  input  logic [DataBits-1:0]    in,                // Input data
  output logic [DataBits-1:0]    out,               // Held until next result
  output memoryPkg::errorT       error,
  output logic                   done               // One cycle after an action
);

  logic                   notAllocated;
  logic                   freed;
  logic                   outOfMemory;
  logic [AddressBits-1:0] allocNumber;              // Next array handed out
  logic [IndexBits:0]     arraySize;
  logic                   inBounds;
  logic                   full;
  logic                   empty;
  logic [DataBits-1:0]    readData;
  logic [DataBits-1:0]    modifyResult;
  logic                   doAlloc;
  logic                   doFree;
  logic                   doWrite;
  logic                   doPush;
  logic                   doPop;
  logic                   doModify;
  memoryPkg::aluOpT       aluOp;

  commandControl #(.AddressBits(AddressBits), .IndexBits(IndexBits), .DataBits(DataBits))
    control (
      .clock, .arstN, .action, .in,
      .notAllocated, .freed, .outOfMemory, .allocNumber,
      .arraySize, .inBounds, .full, .empty,
      .readData, .modifyResult,
      .doAlloc, .doFree, .doWrite, .doPush, .doPop, .doModify,
      .aluOp, .out, .error, .done
    );

  arrayAllocator #(.AddressBits(AddressBits))
    allocator (
      .clock, .arstN, .array, .doAlloc, .doFree,
      .notAllocated, .freed, .outOfMemory, .allocNumber
    );

  sizeTable #(.AddressBits(AddressBits), .IndexBits(IndexBits))
    sizes (
      .clock, .arstN, .array, .index, .allocNumber,
      .doAlloc, .doWrite, .doPush, .doPop,
      .arraySize, .inBounds, .full, .empty
    );

  elementStore #(.AddressBits(AddressBits), .IndexBits(IndexBits), .DataBits(DataBits))
    store (
      .clock, .arstN, .array, .index, .in, .arraySize,
      .doWrite, .doPush, .doPop, .doModify, .aluOp,
      .readData, .modifyResult
    );

endmodule

//--- src/commandControl.sv
/*
  Decodes the client action, ranks the error checks and raises one commit
  strobe for the state modules. Registers out, error and done.
*/
`timescale 1ns/1ps

module commandControl #(
  parameter int AddressBits = 3,
  parameter int IndexBits   = 3,
  parameter int DataBits    = 16
) (
  input  logic                   clock,
  input  logic                   arstN,
  input  memoryPkg::actionT      action,
  input  logic [DataBits-1:0]    in,
  input  logic                   notAllocated,
  input  logic                   freed,
  input  logic                   outOfMemory,
  input  logic [AddressBits-1:0] allocNumber,
  input  logic [IndexBits:0]     arraySize,
  input  logic                   inBounds,
  input  logic                   full,
  input  logic                   empty,
  input  logic [DataBits-1:0]    readData,
  input  logic [DataBits-1:0]    modifyResult,
  output logic                   doAlloc,
  output logic                   doFree,
  output logic                   doWrite,
  output logic                   doPush,
  output logic                   doPop,
  output logic                   doModify,
  output memoryPkg::aluOpT       aluOp,
  output logic [DataBits-1:0]    out,
  output memoryPkg::errorT       error,
  output logic                   done
);

  logic              needLive;                      // Array must be allocated and live
  logic              needBounds;                    // Index must be inside size
  logic              isModify;
  logic              badAction;
  logic              commit;
  logic              returnsValue;
  logic [DataBits-1:0] nextOut;
  memoryPkg::errorT  errCode;

  always_comb begin
    needLive   = 1'b1;
    needBounds = 1'b0;
    isModify   = 1'b0;
    badAction  = 1'b0;
    aluOp      = memoryPkg::aluAdd;
    case (action)
      memoryPkg::actIdle, memoryPkg::actAlloc: needLive = 1'b0;
      memoryPkg::actWrite, memoryPkg::actSize, memoryPkg::actFree,
      memoryPkg::actPush, memoryPkg::actPop: ;
      memoryPkg::actRead: needBounds = 1'b1;
      memoryPkg::actAdd, memoryPkg::actAddAfter: isModify = 1'b1;
      memoryPkg::actSubtract, memoryPkg::actSubAfter: begin
        isModify = 1'b1;
        aluOp    = memoryPkg::aluSubtract;
      end
      memoryPkg::actOr: begin
        isModify = 1'b1;
        aluOp    = memoryPkg::aluOr;
      end
      memoryPkg::actXor: begin
        isModify = 1'b1;
        aluOp    = memoryPkg::aluXor;
      end
      memoryPkg::actAnd: begin
        isModify = 1'b1;
        aluOp    = memoryPkg::aluAnd;
      end
      memoryPkg::actNot: begin
        isModify = 1'b1;
        aluOp    = memoryPkg::aluNot;
      end
      memoryPkg::actNotLogical: begin
        isModify = 1'b1;
        aluOp    = memoryPkg::aluNotLogical;
      end
      default: begin
        needLive  = 1'b0;
        badAction = 1'b1;
      end
    endcase
    needBounds = needBounds | isModify;

    // First failing check wins
    if (badAction) errCode = memoryPkg::errBadAction;
    else if (action == memoryPkg::actAlloc && outOfMemory) errCode = memoryPkg::errOutOfMemory;
    else if (needLive && notAllocated) errCode = memoryPkg::errNotAllocated;
    else if (needLive && freed) errCode = memoryPkg::errFreed;
    else if (needBounds && !inBounds) errCode = memoryPkg::errOutOfBounds;
    else if (action == memoryPkg::actPush && full) errCode = memoryPkg::errFull;
    else if (action == memoryPkg::actPop && empty) errCode = memoryPkg::errEmpty;
    else errCode = memoryPkg::errNone;
  end

  assign commit   = action != memoryPkg::actIdle && errCode == memoryPkg::errNone;
  assign doAlloc  = commit && action == memoryPkg::actAlloc;
  assign doFree   = commit && action == memoryPkg::actFree;
  assign doWrite  = commit && action == memoryPkg::actWrite;
  assign doPush   = commit && action == memoryPkg::actPush;
  assign doPop    = commit && action == memoryPkg::actPop;
  assign doModify = commit && isModify;

  // Push and Free leave out alone
  assign returnsValue = commit && !doPush && !doFree;

  always_comb begin
    case (action)
      memoryPkg::actAlloc: nextOut = DataBits'(allocNumber);
      memoryPkg::actSize:  nextOut = DataBits'(arraySize);
      memoryPkg::actWrite: nextOut = in;              // Echo written value
      memoryPkg::actRead, memoryPkg::actPop,
      memoryPkg::actAddAfter, memoryPkg::actSubAfter: nextOut = readData;
      default:             nextOut = modifyResult;
    endcase
  end

  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      out   <= '0;
      error <= memoryPkg::errNone;
      done  <= 1'b0;
    end else begin
      done <= action != memoryPkg::actIdle;
      if (action != memoryPkg::actIdle) error <= errCode;
      if (returnsValue) out <= nextOut;
    end
  end

  oneStrobe: assert property (@(posedge clock) disable iff (!arstN)
    $onehot0({doAlloc, doFree, doWrite, doPush, doPop, doModify}));

endmodule

//--- src/arrayAllocator.sv
/*
  Hands out array numbers. New numbers come from a running count, freed
  ones are reused last in first out. Reports the status of the addressed array.
*/
`timescale 1ns/1ps

module arrayAllocator #(
  parameter int AddressBits = 3
) (
  input  logic                   clock,
  input  logic                   arstN,
  input  logic [AddressBits-1:0] array,
  input  logic                   doAlloc,
  input  logic                   doFree,
  output logic                   notAllocated,      // Never handed out
  output logic                   freed,             // Handed out, then freed
  output logic                   outOfMemory,
  output logic [AddressBits-1:0] allocNumber        // Number the next Alloc returns
);

  localparam int ArrayCount = 2 ** AddressBits;

  logic [AddressBits:0]   allocCount;               // Arrays handed out so far
  logic [AddressBits:0]   stackPointer;             // Entries on the freed stack
  logic [ArrayCount-1:0]  live;                     // One flag per array
  logic [AddressBits-1:0] freedStack [ArrayCount];
  logic                   stackEmpty;
  logic [AddressBits:0]   stackTop;

  assign stackEmpty = stackPointer == '0;
  assign stackTop   = stackPointer - 1'b1;

  // Reuse beats fresh numbers
  always_comb begin
    if (!stackEmpty) allocNumber = freedStack[stackTop[AddressBits-1:0]];
    else allocNumber = allocCount[AddressBits-1:0];
  end

  assign outOfMemory  = allocCount == (AddressBits+1)'(ArrayCount) && stackEmpty;
  assign notAllocated = {1'b0, array} >= allocCount;
  assign freed        = !notAllocated && !live[array];

  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      allocCount   <= '0;
      stackPointer <= '0;
      live         <= '0;
      for (int a = 0; a < ArrayCount; a++) begin
        freedStack[a] <= '0;
      end
    end else if (doAlloc) begin
      live[allocNumber] <= 1'b1;
      if (!stackEmpty) begin
        stackPointer <= stackTop;                   // Pop the freed stack
      end else begin
        allocCount <= allocCount + 1'b1;
      end
    end else if (doFree) begin
      live[array]  <= 1'b0;
      freedStack[stackPointer[AddressBits-1:0]] <= array;  // Push the freed number
      stackPointer <= stackPointer + 1'b1;
    end
  end

  // Double frees are rejected upstream, so the stack cannot overflow
  stackLimit: assert property (@(posedge clock) disable iff (!arstN)
    stackPointer <= (AddressBits+1)'(ArrayCount));

endmodule

//--- src/sizeTable.sv
/*
  Holds the current size of every array and reports bounds, full and empty
  for the addressed array. Sizes change only on commit strobes.
*/
`timescale 1ns/1ps

module sizeTable #(
  parameter int AddressBits = 3,
  parameter int IndexBits   = 3
) (
  input  logic                   clock,
  input  logic                   arstN,
  input  logic [AddressBits-1:0] array,
  input  logic [IndexBits-1:0]   index,
  input  logic [AddressBits-1:0] allocNumber,
  input  logic                   doAlloc,
  input  logic                   doWrite,
  input  logic                   doPush,
  input  logic                   doPop,
  output logic [IndexBits:0]     arraySize,
  output logic                   inBounds,
  output logic                   full,
  output logic                   empty
);

  localparam int ArrayCount  = 2 ** AddressBits;
  localparam int ArrayLength = 2 ** IndexBits;

  logic [IndexBits:0]     sizes [ArrayCount];       // One extra bit to hold a full array
  logic                   sizeEnable;
  logic [AddressBits-1:0] sizeSlot;
  logic [IndexBits:0]     sizeValue;

  assign arraySize = sizes[array];
  assign inBounds  = {1'b0, index} < arraySize;
  assign full      = arraySize == (IndexBits+1)'(ArrayLength);
  assign empty     = arraySize == '0;

  always_comb begin
    sizeEnable = doAlloc | doPush | doPop | (doWrite && !inBounds);
    sizeSlot   = doAlloc ? allocNumber : array;
    if (doAlloc) sizeValue = '0;                    // Fresh array starts empty
    else if (doPush) sizeValue = arraySize + 1'b1;
    else if (doPop) sizeValue = arraySize - 1'b1;
    else sizeValue = {1'b0, index} + 1'b1;          // Write past the end
  end

  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      for (int a = 0; a < ArrayCount; a++) begin
        sizes[a] <= '0;
      end
    end else if (sizeEnable) begin
      sizes[sizeSlot] <= sizeValue;
    end
  end

  for (genvar a = 0; a < ArrayCount; a++) begin : gSizeCheck
    sizeLimit: assert property (@(posedge clock) disable iff (!arstN)
      sizes[a] <= (IndexBits+1)'(ArrayLength));
  end

endmodule

//--- src/elementStore.sv
/*
  Element storage for all arrays. Selects the element to read, feeds it
  through the ALU for modify actions and writes back on commit strobes.
*/
`timescale 1ns/1ps

module elementStore #(
  parameter int AddressBits = 3,
  parameter int IndexBits   = 3,
  parameter int DataBits    = 16
) (
  input  logic                   clock,
  input  logic                   arstN,
  input  logic [AddressBits-1:0] array,
  input  logic [IndexBits-1:0]   index,
  input  logic [DataBits-1:0]    in,
  input  logic [IndexBits:0]     arraySize,
  input  logic                   doWrite,
  input  logic                   doPush,
  input  logic                   doPop,
  input  logic                   doModify,
  input  memoryPkg::aluOpT       aluOp,
  output logic [DataBits-1:0]    readData,
  output logic [DataBits-1:0]    modifyResult
);

  localparam int ArrayCount  = 2 ** AddressBits;
  localparam int ArrayLength = 2 ** IndexBits;

  logic [DataBits-1:0]  memory [ArrayCount][ArrayLength];
  logic [IndexBits:0]   lastSlot;                   // Top element for Pop
  logic [IndexBits-1:0] readSlot;
  logic [IndexBits-1:0] writeSlot;
  logic [DataBits-1:0]  writeValue;

  assign lastSlot = arraySize - 1'b1;
  assign readSlot = doPop ? lastSlot[IndexBits-1:0] : index;
  assign readData = memory[array][readSlot];

  elementAlu #(.DataBits(DataBits)) alu (
    .operand(readData), .in, .aluOp, .result(modifyResult)
  );

  assign writeSlot  = doPush ? arraySize[IndexBits-1:0] : index;
  assign writeValue = doModify ? modifyResult : in;

  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      for (int a = 0; a < ArrayCount; a++) begin
        for (int i = 0; i < ArrayLength; i++) begin
          memory[a][i] <= '0;
        end
      end
    end else if (doWrite || doPush || doModify) begin
      memory[array][writeSlot] <= writeValue;
    end
  end

endmodule

//--- src/elementAlu.sv
/*
  Read-modify-write operators on one element. Pure combinational, results
  wrap modulo the data width.
*/
`timescale 1ns/1ps

module elementAlu #(
  parameter int DataBits = 16
) (
  input  logic [DataBits-1:0] operand,              // Current element value
  input  logic [DataBits-1:0] in,
  input  memoryPkg::aluOpT    aluOp,
  output logic [DataBits-1:0] result
);

  logic operandZero;

  assign operandZero = operand == '0;

  always_comb begin
    case (aluOp)
      memoryPkg::aluAdd:        result = operand + in;
      memoryPkg::aluSubtract:   result = operand - in;
      memoryPkg::aluOr:         result = operand | in;
      memoryPkg::aluXor:        result = operand ^ in;
      memoryPkg::aluAnd:        result = operand & in;
      memoryPkg::aluNot:        result = ~operand;
      memoryPkg::aluNotLogical: result = DataBits'(operandZero);
      default:                  result = operand;   // Unused select leaves value
    endcase
  end

endmodule

//--- src/memoryPkg.sv
/*
  Shared codes for the array memory: client action codes, ALU operator
  selects and the error codes reported on the error output.
*/
package memoryPkg;

  // Action codes keep their historic numbers so existing clients still work
  typedef enum logic [7:0] {
    actIdle       = 8'd0,                           // Nothing to do
    actWrite      = 8'd2,                           // Write an element
    actRead       = 8'd3,                           // Read an element
    actSize       = 8'd4,                           // Size of array
    actPush       = 8'd14,                          // Push onto end of array
    actPop        = 8'd15,                          // Pop from end of array
    actAlloc      = 8'd18,                          // Allocate an array
    actFree       = 8'd19,                          // Free an array for reuse
    actAdd        = 8'd20,                          // Add, return new value
    actAddAfter   = 8'd21,                          // Add, return old value
    actSubtract   = 8'd22,                          // Subtract, return new value
    actSubAfter   = 8'd23,                          // Subtract, return old value
    actNotLogical = 8'd26,                          // Logical not
    actNot        = 8'd27,                          // Bitwise not
    actOr         = 8'd28,
    actXor        = 8'd29,
    actAnd        = 8'd30
  } actionT;

  typedef enum logic [2:0] {
    aluAdd,
    aluSubtract,
    aluOr,
    aluXor,
    aluAnd,
    aluNot,                                         // Ignores in
    aluNotLogical                                   // One when operand is zero
  } aluOpT;

  typedef enum logic [3:0] {
    errNone,
    errNotAllocated,                                // Array number never handed out
    errFreed,                                       // Array was freed
    errOutOfBounds,                                 // Index at or past size
    errFull,                                        // Push on a full array
    errEmpty,                                       // Pop on an empty array
    errOutOfMemory,                                 // No array left to allocate
    errBadAction                                    // Unknown action code
  } errorT;

endpackage
